/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  make clean  remove obj_dir and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_fft_tail -Mdir obj_dir -o tb_fft_tail
	./obj_dir/tb_fft_tail > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No verdict found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* include/fft_tail_cfg.svh */
`ifndef FFT_TAIL_CFG_SVH
`define FFT_TAIL_CFG_SVH

// Beat geometry.
`define FFT_LANES   16
`define FFT_BEATS   32
`define FFT_GROUPS  8

// Sample and block index widths.
`define IN_W        12
`define BEXP_W      5

// W8 twiddle, 256 is unity.
`define TW_C181     181
`define TW_ROUND    128
`define TW_SHIFT    8

// Renormalization.
`define NORM_REF    9
`define NORM_ZERO   22
`define BFLY_LAT    5

`endif

/* sim.f */
+incdir+include
verilog/fft_tail_pkg.sv
verilog/bfly_stage_j.sv
verilog/bfly_stage_w8.sv
verilog/bfly_stage_sat.sv
verilog/exponent_sum.sv
verilog/block_normalizer.sv
verilog/fft_tail_top.sv
sim/tb_fft_tail.sv

/* sim/tb_fft_tail.sv */
`include "fft_tail_cfg.svh"

module tb_fft_tail import fft_tail_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS      = 10;
    localparam int LATENCY     = 6;
    localparam int LW          = $bits(s_out_t);
    localparam int HALF        = `FFT_LANES / 2;
    localparam int PER_GRP     = `FFT_BEATS / `FFT_GROUPS;
    // Unity, shift, zero, full scale, back-to-back, broken frame.
    localparam int TOTAL_BEATS = 32 + 64 + 16 + 8 + 64 + 10 + 20;

    typedef logic [2*`FFT_LANES*LW-1:0] exp_beat_t;

    logic       clk;
    logic       rst;
    logic       in_valid;
    s_in_t      in_re [`FFT_LANES];
    s_in_t      in_im [`FFT_LANES];
    bexp_grp_t  bexp_grp;
    bexp_pair_t bexp_pair;
    logic       out_valid;
    s_out_t     out_re [`FFT_LANES];
    s_out_t     out_im [`FFT_LANES];

    logic [31:0] seed = 32'haad85a6b;
    int          cyc = 0;
    int          beat_k = 0;
    int          errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cur_re [`FFT_LANES];
    int          cur_im [`FFT_LANES];
    int          cur_grp [`FFT_GROUPS];
    exp_beat_t   exp_q [$];
    int          due_q [$];

    fft_tail_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_re     (in_re),
        .in_im     (in_im),
        .bexp_grp  (bexp_grp),
        .bexp_pair (bexp_pair),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #((TOTAL_BEATS + 100) * CLK_NS);
        $display("Timeout: the run went past the time allowed for all tests");
        $display("STATUS: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        seed = xorshift(seed);
        return int'(seed % $unsigned(n));
    endfunction

    function automatic int sat16(input int x);
        if (x > 32767)
            return 32767;
        if (x < -32768)
            return -32768;
        return x;
    endfunction

    function automatic int scale_lane(input int x, input int e);
        if (e > `NORM_ZERO)
            return 0;
        if (e > `NORM_REF)
            return x >>> (e - `NORM_REF);
        return x << (`NORM_REF - e);
    endfunction

    function automatic exp_beat_t ref_beat(input int xr [`FFT_LANES],
                                           input int xi [`FFT_LANES],
                                           input int e_lo, input int e_hi);
        int        ar [`FFT_LANES];
        int        ai [`FFT_LANES];
        int        br [`FFT_LANES];
        int        bi [`FFT_LANES];
        int        c;
        int        sr;
        int        si;
        exp_beat_t r;
        c = `TW_C181;
        // Span 4. Lanes 6 and 7 of each half also take -j.
        for (int i = 0; i < `FFT_LANES; i++) begin
            if (i % 8 < 4) begin
                ar[i] = xr[i] + xr[i + 4];
                ai[i] = xi[i] + xi[i + 4];
            end else if (i % 8 < 6) begin
                ar[i] = xr[i - 4] - xr[i];
                ai[i] = xi[i - 4] - xi[i];
            end else begin
                ar[i] = xi[i - 4] - xi[i];
                ai[i] = xr[i] - xr[i - 4];
            end
        end
        // Span 2.
        for (int i = 0; i < `FFT_LANES; i++) begin
            if (i % 4 < 2) begin
                br[i] = ar[i] + ar[i + 2];
                bi[i] = ai[i] + ai[i + 2];
            end else begin
                br[i] = ar[i - 2] - ar[i];
                bi[i] = ai[i - 2] - ai[i];
            end
        end
        for (int i = 3; i < `FFT_LANES; i += 2) begin
            sr = br[i];
            si = bi[i];
            case (i % 8)
                3: begin
                    br[i] = si;
                    bi[i] = -sr;
                end
                5: begin
                    br[i] = (c * sr + c * si + `TW_ROUND) >>> `TW_SHIFT;
                    bi[i] = (c * si - c * sr + `TW_ROUND) >>> `TW_SHIFT;
                end
                7: begin
                    br[i] = (-c * sr + c * si + `TW_ROUND) >>> `TW_SHIFT;
                    bi[i] = (-c * si - c * sr + `TW_ROUND) >>> `TW_SHIFT;
                end
                default: ;
            endcase
        end
        // Span 1 with clamping, then renormalize and keep 13 bits.
        for (int i = 0; i < `FFT_LANES; i++) begin
            if (i % 2 == 0) begin
                sr = sat16(br[i] + br[i + 1]);
                si = sat16(bi[i] + bi[i + 1]);
            end else begin
                sr = sat16(br[i - 1] - br[i]);
                si = sat16(bi[i - 1] - bi[i]);
            end
            r[i*LW +: LW] = LW'(scale_lane(sr, (i < HALF) ? e_lo : e_hi));
            r[(`FFT_LANES + i)*LW +: LW] = LW'(scale_lane(si, (i < HALF) ? e_lo : e_hi));
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_beat(input int p0, input int p1);
        int g;
        @(posedge clk);
        #1;
        g = cur_grp[beat_k / PER_GRP];
        in_valid = 1'b1;
        bexp_pair[0] = bexp_t'(p0);
        bexp_pair[1] = bexp_t'(p1);
        for (int i = 0; i < `FFT_GROUPS; i++)
            bexp_grp[i] = bexp_t'(cur_grp[i]);
        for (int i = 0; i < `FFT_LANES; i++) begin
            in_re[i] = s_in_t'(cur_re[i]);
            in_im[i] = s_in_t'(cur_im[i]);
        end
        exp_q.push_back(ref_beat(cur_re, cur_im, g + p0, g + p1));
        due_q.push_back(cyc + LATENCY);
        beat_k = (beat_k + 1) % `FFT_BEATS;
    endtask

    task automatic random_beat(input int p_base, input int p_span);
        int p0;
        int p1;
        for (int i = 0; i < `FFT_LANES; i++) begin
            cur_re[i] = rand_below(4096) - 2048;
            cur_im[i] = rand_below(4096) - 2048;
        end
        p0 = p_base + rand_below(p_span);
        p1 = p_base + rand_below(p_span);
        drive_beat(p0, p1);
    endtask

    task automatic set_groups(input int base, input int step, input int span);
        for (int g = 0; g < `FFT_GROUPS; g++)
            cur_grp[g] = base + step * g + rand_below(span);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            beat_k = 0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        drive_idle(1);
        while (exp_q.size() != 0 && n < 2 * LATENCY) begin
            @(posedge clk);
            n++;
        end
        @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output checker, sampled mid-cycle.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        exp_beat_t       want;
        int              due;
        logic [LW-1:0]   w_re;
        logic [LW-1:0]   w_im;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output beat at cycle %0d has no matching input beat", cyc);
            end else begin
                want = exp_q.pop_front();
                due = due_q.pop_front();
                if (due != cyc) begin
                    errors++;
                    $display("Output beat came at cycle %0d instead of cycle %0d", cyc, due);
                end
                for (int i = 0; i < `FFT_LANES; i++) begin
                    w_re = want[i*LW +: LW];
                    w_im = want[(`FFT_LANES + i)*LW +: LW];
                    if (out_re[i] !== w_re) begin
                        errors++;
                        $display("FAILED out_re[%0d]: expected %h, got %h", i, w_re, out_re[i]);
                    end
                    if (out_im[i] !== w_im) begin
                        errors++;
                        $display("FAILED out_im[%0d]: expected %h, got %h", i, w_im, out_im[i]);
                    end
                end
            end
        end else if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid is unknown at cycle %0d", cyc);
        end else begin
            for (int i = 0; i < `FFT_LANES; i++) begin
                if (out_re[i] !== '0 || out_im[i] !== '0) begin
                    errors++;
                    $display("FAILED out_re/out_im[%0d]: expected 0/0 while idle, got %h/%h",
                             i, out_re[i], out_im[i]);
                end
            end
        end
    end

    initial begin
        int err_start;
        rst = 1'b0;
        in_valid = 1'b0;
        for (int i = 0; i < `FFT_LANES; i++) begin
            in_re[i] = '0;
            in_im[i] = '0;
        end
        for (int g = 0; g < `FFT_GROUPS; g++)
            bexp_grp[g] = '0;
        bexp_pair[0] = '0;
        bexp_pair[1] = '0;

        err_start = errors;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        drive_idle(12);
        finish_test("reset", err_start);

        // Both sums at 9 leave the butterfly result unscaled.
        err_start = errors;
        set_groups(4, 0, 1);
        repeat (32) random_beat(5, 1);
        wait_drain();
        finish_test("unity", err_start);

        // Sums between 0 and 22, first rising by group, then from the pair alone.
        err_start = errors;
        set_groups(0, 2, 1);
        for (int b = 0; b < `FFT_BEATS; b++)
            random_beat(0, 23 - cur_grp[b / PER_GRP]);
        set_groups(0, 0, 1);
        repeat (32) random_beat(0, 23);
        wait_drain();
        finish_test("shift", err_start);

        err_start = errors;
        set_groups(12, 0, 20);
        repeat (16) random_beat(11, 21);
        drive_idle(1);
        set_groups(4, 0, 1);
        for (int b = 0; b < 8; b++) begin
            for (int i = 0; i < `FFT_LANES; i++) begin
                cur_re[i] = (b % 2 == 0) ? 2047 : -2047;
                cur_im[i] = (b % 4 < 2) ? 2047 : -2047;
            end
            drive_beat(5, 5);
        end
        wait_drain();
        finish_test("zero_sat", err_start);

        // Two frames with no gap, then one frame cut by idle cycles.
        err_start = errors;
        repeat (2) begin
            set_groups(0, 0, 16);
            repeat (32) random_beat(0, 8);
        end
        set_groups(0, 0, 16);
        repeat (10) random_beat(0, 8);
        drive_idle(3);
        repeat (20) random_beat(0, 8);
        wait_drain();
        finish_test("frames", err_start);

        drive_idle(4);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected beats never came out of the DUT", exp_q.size());
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/bfly_stage_j.sv */
`include "fft_tail_cfg.svh"

module bfly_stage_j import fft_tail_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  s_in_t in_re [`FFT_LANES],
    input  s_in_t in_im [`FFT_LANES],
    output logic  j_valid,
    output s_j_t  j_re [`FFT_LANES],
    output s_j_t  j_im [`FFT_LANES]
);

    logic as_valid;
    s_j_t as_re [`FFT_LANES];
    s_j_t as_im [`FFT_LANES];

    // Span 4 within each half beat. Sum low, difference high.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            as_valid <= 1'b0;
            for (int i = 0; i < `FFT_LANES; i++) begin
                as_re[i] <= '0;
                as_im[i] <= '0;
            end
        end else begin
            as_valid <= in_valid;
            if (in_valid) begin
                for (int g = 0; g < `FFT_LANES; g += 8) begin
                    for (int i = g; i < g + 4; i++) begin
                        as_re[i]     <= s_j_t'(in_re[i]) + s_j_t'(in_re[i + 4]);
                        as_im[i]     <= s_j_t'(in_im[i]) + s_j_t'(in_im[i + 4]);
                        as_re[i + 4] <= s_j_t'(in_re[i]) - s_j_t'(in_re[i + 4]);
                        as_im[i + 4] <= s_j_t'(in_im[i]) - s_j_t'(in_im[i + 4]);
                    end
                end
            end
        end
    end

    // -j on lanes 6, 7, 14, 15.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            j_valid <= 1'b0;
            for (int i = 0; i < `FFT_LANES; i++) begin
                j_re[i] <= '0;
                j_im[i] <= '0;
            end
        end else begin
            j_valid <= as_valid;
            if (as_valid) begin
                for (int i = 0; i < `FFT_LANES; i++) begin
                    if ((i % 8) >= 6) begin
                        j_re[i] <= as_im[i];
                        j_im[i] <= -as_re[i];
                    end else begin
                        j_re[i] <= as_re[i];
                        j_im[i] <= as_im[i];
                    end
                end
            end
        end
    end

    a_j_valid_known: assert property (@(posedge clk) disable iff (!rst) !$isunknown(j_valid));

endmodule

/* verilog/bfly_stage_sat.sv */
`include "fft_tail_cfg.svh"

module bfly_stage_sat import fft_tail_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   w8_valid,
    input  s_w8_t  w8_re [`FFT_LANES],
    input  s_w8_t  w8_im [`FFT_LANES],
    output logic   sat_valid,
    output s_sat_t sat_re [`FFT_LANES],
    output s_sat_t sat_im [`FFT_LANES]
);

    localparam int SW      = $bits(s_sat_t) + 1;
    localparam int SAT_MAX = 2 ** ($bits(s_sat_t) - 1) - 1;
    localparam int SAT_MIN = -(2 ** ($bits(s_sat_t) - 1));

    logic signed [SW-1:0] sum_re [`FFT_LANES];
    logic signed [SW-1:0] sum_im [`FFT_LANES];

    function automatic s_sat_t clamp(input logic signed [SW-1:0] x);
        if (x > SAT_MAX)
            return s_sat_t'(SAT_MAX);
        if (x < SAT_MIN)
            return s_sat_t'(SAT_MIN);
        return s_sat_t'(x);
    endfunction

    // Span 1 on neighbouring lanes.
    always_comb begin
        for (int k = 0; k < `FFT_LANES; k += 2) begin
            sum_re[k]     = SW'(w8_re[k]) + SW'(w8_re[k + 1]);
            sum_im[k]     = SW'(w8_im[k]) + SW'(w8_im[k + 1]);
            sum_re[k + 1] = SW'(w8_re[k]) - SW'(w8_re[k + 1]);
            sum_im[k + 1] = SW'(w8_im[k]) - SW'(w8_im[k + 1]);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sat_valid <= 1'b0;
            for (int i = 0; i < `FFT_LANES; i++) begin
                sat_re[i] <= '0;
                sat_im[i] <= '0;
            end
        end else begin
            sat_valid <= w8_valid;
            if (w8_valid) begin
                for (int i = 0; i < `FFT_LANES; i++) begin
                    sat_re[i] <= clamp(sum_re[i]);
                    sat_im[i] <= clamp(sum_im[i]);
                end
            end
        end
    end

    // A clamped lane never wraps to the opposite sign.
    for (genvar i = 0; i < `FFT_LANES; i++) begin : g_chk
        a_no_wrap: assert property (@(posedge clk) disable iff (!rst)
            w8_valid |=> (sat_re[i][SW-2] == $past(sum_re[i][SW-1])) &&
                         (sat_im[i][SW-2] == $past(sum_im[i][SW-1])));
    end

endmodule

/* verilog/bfly_stage_w8.sv */
`include "fft_tail_cfg.svh"

module bfly_stage_w8 import fft_tail_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  j_valid,
    input  s_j_t  j_re [`FFT_LANES],
    input  s_j_t  j_im [`FFT_LANES],
    output logic  w8_valid,
    output s_w8_t w8_re [`FFT_LANES],
    output s_w8_t w8_im [`FFT_LANES]
);

    localparam int AW = $bits(s_j_t) + 1;
    localparam int PW = AW + 9;
    localparam logic signed [8:0] C181 = `TW_C181;

    logic                 as_valid;
    logic signed [AW-1:0] as_re [`FFT_LANES];
    logic signed [AW-1:0] as_im [`FFT_LANES];
    logic signed [PW-1:0] p_re [`FFT_LANES];
    logic signed [PW-1:0] p_im [`FFT_LANES];
    s_w8_t                tw_re [`FFT_LANES];
    s_w8_t                tw_im [`FFT_LANES];

    // Round half up, then drop the fraction.
    function automatic s_w8_t tw_round(input logic signed [PW-1:0] acc);
        logic signed [PW-1:0] r;
        r = acc + PW'(`TW_ROUND);
        return r[`TW_SHIFT +: $bits(s_w8_t)];
    endfunction

    // Span 2 inside each group of four.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            as_valid <= 1'b0;
            for (int i = 0; i < `FFT_LANES; i++) begin
                as_re[i] <= '0;
                as_im[i] <= '0;
            end
        end else begin
            as_valid <= j_valid;
            if (j_valid) begin
                for (int b = 0; b < `FFT_LANES; b += 4) begin
                    for (int i = b; i < b + 2; i++) begin
                        as_re[i]     <= AW'(j_re[i]) + AW'(j_re[i + 2]);
                        as_im[i]     <= AW'(j_im[i]) + AW'(j_im[i + 2]);
                        as_re[i + 2] <= AW'(j_re[i]) - AW'(j_re[i + 2]);
                        as_im[i + 2] <= AW'(j_im[i]) - AW'(j_im[i + 2]);
                    end
                end
            end
        end
    end

    // Twiddles: -j on 3/11, (1-j)/sqrt2 on 5/13, (-1-j)/sqrt2 on 7/15.
    always_comb begin
        for (int i = 0; i < `FFT_LANES; i++) begin
            p_re[i] = as_re[i] * C181;
            p_im[i] = as_im[i] * C181;
            case (i % 8)
                3: begin
                    tw_re[i] = s_w8_t'(as_im[i]);
                    tw_im[i] = -s_w8_t'(as_re[i]);
                end
                5: begin
                    tw_re[i] = tw_round(p_re[i] + p_im[i]);
                    tw_im[i] = tw_round(p_im[i] - p_re[i]);
                end
                7: begin
                    tw_re[i] = tw_round(p_im[i] - p_re[i]);
                    tw_im[i] = tw_round(-p_im[i] - p_re[i]);
                end
                default: begin
                    tw_re[i] = s_w8_t'(as_re[i]);
                    tw_im[i] = s_w8_t'(as_im[i]);
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            w8_valid <= 1'b0;
            for (int i = 0; i < `FFT_LANES; i++) begin
                w8_re[i] <= '0;
                w8_im[i] <= '0;
            end
        end else begin
            w8_valid <= as_valid;
            if (as_valid) begin
                w8_re <= tw_re;
                w8_im <= tw_im;
            end
        end
    end

endmodule

/* verilog/block_normalizer.sv */
`include "fft_tail_cfg.svh"

module block_normalizer import fft_tail_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   sat_valid,
    input  s_sat_t sat_re [`FFT_LANES],
    input  s_sat_t sat_im [`FFT_LANES],
    input  esum_t  esum_lo,
    input  esum_t  esum_hi,
    output logic   out_valid,
    output s_out_t out_re [`FFT_LANES],
    output s_out_t out_im [`FFT_LANES]
);

    localparam esum_t E_REF  = `NORM_REF;
    localparam esum_t E_ZERO = `NORM_ZERO;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shift toward the reference exponent, flush very small blocks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic s_out_t norm_lane(input s_sat_t x, input esum_t e);
        s_sat_t y;
        if (e > E_ZERO)
            y = '0;
        else if (e > E_REF)
            y = x >>> (e - E_REF);
        else
            y = x <<< (E_REF - e);
        // Keep the low bits only.
        return s_out_t'(y);
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < `FFT_LANES; i++) begin
                out_re[i] <= '0;
                out_im[i] <= '0;
            end
        end else begin
            out_valid <= sat_valid;
            for (int i = 0; i < `FFT_LANES; i++) begin
                if (!sat_valid) begin
                    out_re[i] <= '0;
                    out_im[i] <= '0;
                end else if (i < `FFT_LANES / 2) begin
                    out_re[i] <= norm_lane(sat_re[i], esum_lo);
                    out_im[i] <= norm_lane(sat_im[i], esum_lo);
                end else begin
                    out_re[i] <= norm_lane(sat_re[i], esum_hi);
                    out_im[i] <= norm_lane(sat_im[i], esum_hi);
                end
            end
        end
    end

endmodule

/* verilog/exponent_sum.sv */
module exponent_sum import fft_tail_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  bexp_grp_t  bexp_grp,
    input  bexp_pair_t bexp_pair,
    output esum_t      esum_lo,
    output esum_t      esum_hi
);

    beat_t     beat;
    grp_t      grp;
    esum_t     sum_lo;
    esum_t     sum_hi;
    esum_dly_t lo_dly;
    esum_dly_t hi_dly;

    // Four beats share one stage-0 block index.
    assign grp = beat[$bits(beat_t)-1 -: $bits(grp_t)];

    // Frame length is a power of two, so the counter wraps on its own.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat   <= '0;
            sum_lo <= '0;
            sum_hi <= '0;
        end else if (in_valid) begin
            beat   <= beat + beat_t'(1);
            sum_lo <= esum_t'(bexp_grp[grp]) + esum_t'(bexp_pair[0]);
            sum_hi <= esum_t'(bexp_grp[grp]) + esum_t'(bexp_pair[1]);
        end else begin
            beat   <= '0;
            sum_lo <= '0;
            sum_hi <= '0;
        end
    end

    // Delay to line up with the saturated beat.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < $size(lo_dly); i++) begin
                lo_dly[i] <= '0;
                hi_dly[i] <= '0;
            end
        end else begin
            lo_dly[0] <= sum_lo;
            hi_dly[0] <= sum_hi;
            for (int i = 1; i < $size(lo_dly); i++) begin
                lo_dly[i] <= lo_dly[i - 1];
                hi_dly[i] <= hi_dly[i - 1];
            end
        end
    end

    assign esum_lo = lo_dly[$size(lo_dly) - 1];
    assign esum_hi = hi_dly[$size(hi_dly) - 1];

endmodule

/* verilog/fft_tail_pkg.sv */
`include "fft_tail_cfg.svh"

package fft_tail_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane samples, growing one bit per add stage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [`IN_W-1:0] s_in_t;
    typedef logic signed [`IN_W:0]   s_j_t;
    typedef logic signed [`IN_W+2:0] s_w8_t;
    typedef logic signed [`IN_W+3:0] s_sat_t;
    typedef logic signed [`IN_W:0]   s_out_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Block exponents.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`BEXP_W-1:0] bexp_t;
    typedef logic [`BEXP_W:0]   esum_t;

    typedef bexp_t bexp_grp_t [`FFT_GROUPS];
    typedef bexp_t bexp_pair_t [2];

    // Beat within a frame and the stage-0 group it falls in.
    typedef logic [$clog2(`FFT_BEATS)-1:0]  beat_t;
    typedef logic [$clog2(`FFT_GROUPS)-1:0] grp_t;

    // Exponent delay after the sum register.
    typedef esum_t esum_dly_t [`BFLY_LAT-1];

endpackage

/* verilog/fft_tail_top.sv */
`include "fft_tail_cfg.svh"

module fft_tail_top import fft_tail_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  s_in_t      in_re [`FFT_LANES],
    input  s_in_t      in_im [`FFT_LANES],
    input  bexp_grp_t  bexp_grp,
    input  bexp_pair_t bexp_pair,
    output logic       out_valid,
    output s_out_t     out_re [`FFT_LANES],
    output s_out_t     out_im [`FFT_LANES]
);

    logic   j_valid;
    s_j_t   j_re [`FFT_LANES];
    s_j_t   j_im [`FFT_LANES];
    logic   w8_valid;
    s_w8_t  w8_re [`FFT_LANES];
    s_w8_t  w8_im [`FFT_LANES];
    logic   sat_valid;
    s_sat_t sat_re [`FFT_LANES];
    s_sat_t sat_im [`FFT_LANES];
    esum_t  esum_lo;
    esum_t  esum_hi;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Butterfly path, 5 cycles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bfly_stage_j u_stage_j (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_re    (in_re),
        .in_im    (in_im),
        .j_valid  (j_valid),
        .j_re     (j_re),
        .j_im     (j_im)
    );

    bfly_stage_w8 u_stage_w8 (
        .clk      (clk),
        .rst      (rst),
        .j_valid  (j_valid),
        .j_re     (j_re),
        .j_im     (j_im),
        .w8_valid (w8_valid),
        .w8_re    (w8_re),
        .w8_im    (w8_im)
    );

    bfly_stage_sat u_stage_sat (
        .clk       (clk),
        .rst       (rst),
        .w8_valid  (w8_valid),
        .w8_re     (w8_re),
        .w8_im     (w8_im),
        .sat_valid (sat_valid),
        .sat_re    (sat_re),
        .sat_im    (sat_im)
    );

    // Exponent path runs beside the butterflies.
    exponent_sum u_exponent_sum (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .bexp_grp  (bexp_grp),
        .bexp_pair (bexp_pair),
        .esum_lo   (esum_lo),
        .esum_hi   (esum_hi)
    );

    block_normalizer u_normalizer (
        .clk       (clk),
        .rst       (rst),
        .sat_valid (sat_valid),
        .sat_re    (sat_re),
        .sat_im    (sat_im),
        .esum_lo   (esum_lo),
        .esum_hi   (esum_hi),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im)
    );

endmodule
